//--- rtl/ahbMasterPort.sv
// Master side of the matrix; decodes the slave map, holds ungranted requests, answers unmapped ones

module ahbMasterPort import ahbMatrixPkg::*; #(
  parameter int                           SLAVES   = 2,
  parameter logic [SLAVES-1:0][ADDR_W-1:0] SLV_BASE = '0,
  parameter logic [SLAVES-1:0][ADDR_W-1:0] SLV_MASK = '0
) (
  input  logic                    HCLK,
  input  logic                    rstN,

  // From the AHB master
  input  ahbReq_t                 req,
  input  logic [DATA_W-1:0]       hwdata,
  input  logic                    hready,
  output ahbRsp_t                 rsp,

  // Towards the slave ports
  output ahbReq_t                 fwdReq,
  output logic [SLAVES-1:0]       selVec,
  output logic [DATA_W-1:0]       fwdHwdata,
  output logic                    canSwitch,
  input  logic [SLAVES-1:0]       grant,
  input  ahbRsp_t [SLAVES-1:0]    slvRsp
);

  mpState_e          state;
  ahbReq_t           pendQ;
  ahbReq_t           curReq;
  ahbRsp_t           dataRsp;
  logic [SLAVES-1:0] dataSlvQ;
  logic [SLAVES-1:0] hitVec;
  logic [SLAVES-1:0] slvReady;
  logic              reqValid;
  logic              curValid;
  logic              mapped;
  logic              taken;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////////////////////

  // BUSY and IDLE carry no transfer
  assign reqValid = req.sel && (req.trans == NONSEQ || req.trans == SEQ);

  // Held request replays first; a new one only when the last data phase ends
  assign curReq   = (state == MP_PEND) ? pendQ : req;
  assign curValid = (state == MP_PEND) || (reqValid && hready && rsp.ready);

  // Slave map decode, lowest matching slave wins on overlap
  always_comb begin
    hitVec = '0;
    mapped = 1'b0;
    for (int s = 0; s < SLAVES; s++) begin
      if (!mapped && ((curReq.addr & SLV_MASK[s]) == SLV_BASE[s])) begin
        hitVec[s] = 1'b1;
        mapped    = 1'b1;
      end
    end
  end

  assign selVec = (curValid && mapped) ? hitVec : '0;

  // Request seen by the slave ports, IDLE when nothing is selected
  always_comb begin
    fwdReq     = curReq;
    fwdReq.sel = |selVec;
    if (selVec == '0) begin
      fwdReq.trans = IDLE;
    end
  end

  // Accepted when granted and the target's previous data phase has ended
  always_comb begin
    for (int s = 0; s < SLAVES; s++) begin
      slvReady[s] = slvRsp[s].ready;
    end
  end

  assign taken = |(selVec & grant & slvReady);

  ////////////////////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////////////////////

  // Response of the slave owning this master's data phase
  always_comb begin
    dataRsp = '{rdata: '0, ready: 1'b1, resp: OKAY};
    for (int s = 0; s < SLAVES; s++) begin
      if (dataSlvQ[s]) begin
        dataRsp = slvRsp[s];
      end
    end
  end

  // Write data only travels during a data phase
  assign fwdHwdata = (state == MP_DATA) ? hwdata : '0;

  // Slaves may re-arbitrate unless this master is mid data phase
  assign canSwitch = (state != MP_DATA) || dataRsp.ready;

  // Master-side response per FSM state
  always_comb begin
    rsp = '{rdata: '0, ready: 1'b1, resp: OKAY};
    case (state)
      MP_PEND: rsp.ready = 1'b0;
      MP_DATA: rsp = dataRsp;
      MP_ERR1: begin
        rsp.ready = 1'b0;
        rsp.resp  = ERROR;
      end
      MP_ERR2: rsp.resp = ERROR;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      state    <= MP_IDLE;
      dataSlvQ <= '0;
    end else if (curValid && !mapped) begin
      // Default slave, ERROR low-ready then high-ready
      state    <= MP_ERR1;
      dataSlvQ <= '0;
    end else if (taken) begin
      state    <= MP_DATA;
      dataSlvQ <= hitVec;
    end else if (curValid) begin
      state    <= MP_PEND;
      dataSlvQ <= '0;
    end else if (state == MP_ERR1) begin
      state <= MP_ERR2;
    end else if (state != MP_DATA || dataRsp.ready) begin
      state    <= MP_IDLE;
      dataSlvQ <= '0;
    end
  end

  // Hold the address phase that found no grant
  always_ff @(posedge HCLK) begin
    if (curValid && mapped && !taken) begin
      pendQ <= curReq;
    end
  end

endmodule

//--- rtl/ahbMatrix.sv
// AHB-Lite multilayer matrix top; instantiates master and slave ports and wires the crossbar

module ahbMatrix import ahbMatrixPkg::*; #(
  parameter int                           MASTERS  = 2,
  parameter int                           SLAVES   = 2,
  parameter logic [SLAVES-1:0][ADDR_W-1:0] SLV_BASE = {32'h1000_0000, 32'h0000_0000},
  parameter logic [SLAVES-1:0][ADDR_W-1:0] SLV_MASK = {32'hf000_0000, 32'hf000_0000}
) (
  input  logic                           HCLK,
  input  logic                           rstN,

  // AHB masters connect here
  input  ahbReq_t [MASTERS-1:0]          mstReq,
  input  logic [MASTERS-1:0][DATA_W-1:0] mstHwdata,
  input  logic [MASTERS-1:0]             mstHready,
  output ahbRsp_t [MASTERS-1:0]          mstRsp,

  // AHB slaves connect here
  output ahbReq_t [SLAVES-1:0]           slvReq,
  output logic [SLAVES-1:0][DATA_W-1:0]  slvHwdata,
  output logic [SLAVES-1:0]              slvHready,
  input  ahbRsp_t [SLAVES-1:0]           slvRsp
);

  // Master side of the crossbar
  ahbReq_t [MASTERS-1:0]             fwdReq;
  logic [MASTERS-1:0][SLAVES-1:0]    selVec;
  logic [MASTERS-1:0][DATA_W-1:0]    fwdHwdata;
  logic [MASTERS-1:0]                canSwitch;
  logic [MASTERS-1:0][SLAVES-1:0]    mstGrant;

  // Slave side of the crossbar
  logic [SLAVES-1:0][MASTERS-1:0]    slvSel;
  logic [SLAVES-1:0][MASTERS-1:0]    grant;
  ahbRsp_t [SLAVES-1:0]              rsp;

  for (genvar m = 0; m < MASTERS; m++) begin : genMasterPorts
    ahbMasterPort #(
      .SLAVES  (SLAVES),
      .SLV_BASE(SLV_BASE),
      .SLV_MASK(SLV_MASK)
    ) masterPort (
      .HCLK     (HCLK),
      .rstN     (rstN),
      .req      (mstReq[m]),
      .hwdata   (mstHwdata[m]),
      .hready   (mstHready[m]),
      .rsp      (mstRsp[m]),
      .fwdReq   (fwdReq[m]),
      .selVec   (selVec[m]),
      .fwdHwdata(fwdHwdata[m]),
      .canSwitch(canSwitch[m]),
      .grant    (mstGrant[m]),
      .slvRsp   (rsp)
    );
  end

  // Transpose selects towards the slaves and grants back to the masters
  for (genvar s = 0; s < SLAVES; s++) begin : genCross
    for (genvar m = 0; m < MASTERS; m++) begin : genMst
      assign slvSel[s][m]   = selVec[m][s];
      assign mstGrant[m][s] = grant[s][m];
    end
  end

  for (genvar s = 0; s < SLAVES; s++) begin : genSlavePorts
    ahbSlavePort #(
      .MASTERS(MASTERS)
    ) slavePort (
      .HCLK     (HCLK),
      .rstN     (rstN),
      .mstReq   (fwdReq),
      .mstSel   (slvSel[s]),
      .mstHwdata(fwdHwdata),
      .canSwitch(canSwitch),
      .grant    (grant[s]),
      .rsp      (rsp[s]),
      .slvReq   (slvReq[s]),
      .slvHwdata(slvHwdata[s]),
      .slvHready(slvHready[s]),
      .slvRsp   (slvRsp[s])
    );
  end

endmodule

//--- rtl/ahbMatrixPkg.sv
// Shared widths, encodings and bus structs for the AHB-Lite matrix, imported by every module

package ahbMatrixPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  // Address and data buses
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Master priority, higher value wins
  localparam int PRIO_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // HTRANS as on the AHB-Lite bus
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } ahbTrans_e;

  // HRESP, one bit in AHB-Lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } ahbResp_e;

  // Master port FSM
  // ERR1 and ERR2 form the two-cycle ERROR response
  typedef enum logic [2:0] {
    MP_IDLE,
    MP_PEND,
    MP_DATA,
    MP_ERR1,
    MP_ERR2
  } mpState_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////////////////////

  // Address phase of one master
  typedef struct packed {
    logic              sel;
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [2:0]        size;
    ahbTrans_e         trans;
    logic [PRIO_W-1:0] prio;
  } ahbReq_t;

  // Data phase response
  // Ready is HREADYOUT on the slave side, HREADY on the master side
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ready;
    ahbResp_e          resp;
  } ahbRsp_t;

endpackage

//--- rtl/ahbSlavePort.sv
// Slave side of the matrix; arbitrates among masters and steers the data phase of the owner

module ahbSlavePort import ahbMatrixPkg::*; #(
  parameter int MASTERS = 2
) (
  input  logic                           HCLK,
  input  logic                           rstN,

  // From the master ports
  input  ahbReq_t [MASTERS-1:0]          mstReq,
  input  logic [MASTERS-1:0]             mstSel,
  input  logic [MASTERS-1:0][DATA_W-1:0] mstHwdata,
  input  logic [MASTERS-1:0]             canSwitch,
  output logic [MASTERS-1:0]             grant,
  output ahbRsp_t                        rsp,

  // Towards the AHB slave
  output ahbReq_t                        slvReq,
  output logic [DATA_W-1:0]              slvHwdata,
  output logic                           slvHready,
  input  ahbRsp_t                        slvRsp
);

  localparam int IDX_W = (MASTERS > 1) ? $clog2(MASTERS) : 1;

  logic [MASTERS-1:0] reqVec;
  logic [MASTERS-1:0] arbGrant;
  logic [MASTERS-1:0] ownQ;
  logic [MASTERS-1:0] dataOwnQ;
  logic [IDX_W-1:0]   lastQ;
  logic [IDX_W-1:0]   arbIdx;
  logic [PRIO_W-1:0]  bestPrio;
  logic               switchOk;
  logic               arbDone;

  // Masters that address this slave with a real transfer
  always_comb begin
    for (int m = 0; m < MASTERS; m++) begin
      reqVec[m] = mstSel[m] && (mstReq[m].trans == NONSEQ || mstReq[m].trans == SEQ);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////////////////////////////////////////

  // Highest priority among the requesters
  always_comb begin
    bestPrio = '0;
    for (int m = 0; m < MASTERS; m++) begin
      if (reqVec[m] && mstReq[m].prio >= bestPrio) begin
        bestPrio = mstReq[m].prio;
      end
    end
  end

  // Round robin among equal priorities, search starts after the last winner
  always_comb begin
    int cand;
    arbGrant = '0;
    arbIdx   = lastQ;
    arbDone  = 1'b0;
    for (int i = 1; i <= MASTERS; i++) begin
      cand = (int'(lastQ) + i) % MASTERS;
      if (!arbDone && reqVec[cand] && mstReq[cand].prio == bestPrio) begin
        arbGrant[cand] = 1'b1;
        arbIdx         = IDX_W'(cand);
        arbDone        = 1'b1;
      end
    end
  end

  // Switch only once the owner lets go and its data phase is done
  assign switchOk = (ownQ == '0) || ((|(ownQ & canSwitch)) && slvRsp.ready);
  assign grant    = switchOk ? arbGrant : ownQ;

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      ownQ  <= '0;
      lastQ <= '0;
    end else begin
      ownQ <= grant;
      if (switchOk && arbGrant != '0) begin
        lastQ <= arbIdx;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data phase steering
  ////////////////////////////////////////////////////////////////////////////

  // Granted address phase, IDLE when the owner has nothing for us
  always_comb begin
    slvReq = '{sel: 1'b0, addr: '0, write: 1'b0, size: '0, trans: IDLE, prio: '0};
    for (int m = 0; m < MASTERS; m++) begin
      if (grant[m] && reqVec[m]) begin
        slvReq     = mstReq[m];
        slvReq.sel = 1'b1;
      end
    end
  end

  // Single slave behind this port, so its HREADYOUT is its HREADY
  assign slvHready = slvRsp.ready;

  // Data phase owner moves on every completed phase
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      dataOwnQ <= '0;
    end else if (slvRsp.ready) begin
      dataOwnQ <= grant & reqVec;
    end
  end

  // Write data of the data phase owner
  always_comb begin
    slvHwdata = '0;
    for (int m = 0; m < MASTERS; m++) begin
      if (dataOwnQ[m]) begin
        slvHwdata = mstHwdata[m];
      end
    end
  end

  // Response only carries an ERROR for a real owner
  always_comb begin
    rsp = slvRsp;
    if (dataOwnQ == '0) begin
      rsp.resp = OKAY;
    end
  end

endmodule

//--- sim.f
rtl/ahbMatrixPkg.sv
rtl/ahbMasterPort.sv
rtl/ahbSlavePort.sv
rtl/ahbMatrix.sv
test/ahbSlaveMem.sv
test/ahbMatrix_checker.sv
test/ahbMatrixTb.sv

//--- test/ahbMatrixTb.sv
// Testbench top that replays the vector file into the matrix and checks every response

module ahbMatrixTb import ahbMatrixPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MASTERS = 2;
  localparam int SLAVES  = 2;
  localparam logic [SLAVES-1:0][ADDR_W-1:0] SLV_BASE = {32'h1000_0000, 32'h0000_0000};
  localparam logic [SLAVES-1:0][ADDR_W-1:0] SLV_MASK = {32'hf000_0000, 32'hf000_0000};
  localparam int MAX_VEC = 64;

  logic                           HCLK;
  logic                           rstN;
  ahbReq_t [MASTERS-1:0]          mstReq;
  logic [MASTERS-1:0][DATA_W-1:0] mstHwdata;
  logic [MASTERS-1:0]             mstHready;
  ahbRsp_t [MASTERS-1:0]          mstRsp;
  ahbReq_t [SLAVES-1:0]           slvReq;
  logic [SLAVES-1:0][DATA_W-1:0]  slvHwdata;
  logic [SLAVES-1:0]              slvHready;
  ahbRsp_t [SLAVES-1:0]           slvRsp;

  // Vector table with one entry per file line
  int                vStep  [MAX_VEC];
  int                vMst   [MAX_VEC];
  logic              vWrite [MAX_VEC];
  logic [ADDR_W-1:0] vAddr  [MAX_VEC];
  logic [DATA_W-1:0] vWdata [MAX_VEC];
  logic [DATA_W-1:0] vRdata [MAX_VEC];
  ahbResp_e          vResp  [MAX_VEC];
  logic [PRIO_W-1:0] vPrio  [MAX_VEC];
  int                vecCount;
  logic              vecsLoaded = 1'b0;

  // Address phases each slave should see in order
  ahbReq_t expOrder [SLAVES][$];

  ahbMatrix #(
    .MASTERS (MASTERS),
    .SLAVES  (SLAVES),
    .SLV_BASE(SLV_BASE),
    .SLV_MASK(SLV_MASK)
  ) ahbMatrix_i (.*);

  for (genvar s = 0; s < SLAVES; s++) begin : genMem
    ahbSlaveMem slaveMem (
      .HCLK  (HCLK),
      .rstN  (rstN),
      .req   (slvReq[s]),
      .hwdata(slvHwdata[s]),
      .hready(slvHready[s]),
      .rsp   (slvRsp[s])
    );
  end

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkRsp(input string name, input ahbRsp_t got, input ahbRsp_t exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkReq(input string name, input ahbReq_t got, input ahbReq_t exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkReady(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  // Slave that owns an address by the base and mask map or -1 when unmapped
  function automatic int mapSlave(input logic [ADDR_W-1:0] addr);
    for (int s = 0; s < SLAVES; s++) begin
      if ((addr & SLV_MASK[s]) == SLV_BASE[s]) begin
        return s;
      end
    end
    return -1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Vector reader
  ////////////////////////////////////////////////////////////////////////////

  task automatic readVectors();
    int          fd;
    int          n;
    int          step;
    int          mst;
    int          wr;
    int          resp;
    int          prio;
    int          s;
    string       line;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    fd = $fopen("test/ahbMatrixVectors.txt", "r");
    if (fd == 0) begin
      stopOnError("Cannot open the vector file");
    end
    vecCount = 0;
    while ($fgets(line, fd) > 0) begin
      if (line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %h %h %h %d %d", step, mst, wr, addr, wdata, rdata, resp, prio);
      if (n == 8) begin
        vStep[vecCount]  = step;
        vMst[vecCount]   = mst;
        vWrite[vecCount] = (wr != 0);
        vAddr[vecCount]  = addr;
        vWdata[vecCount] = wdata;
        vRdata[vecCount] = rdata;
        vResp[vecCount]  = (resp != 0) ? ERROR : OKAY;
        vPrio[vecCount]  = PRIO_W'(prio);
        // File order within a step is the expected grant order
        s = mapSlave(addr);
        if (s >= 0) begin
          expOrder[s].push_back('{sel: 1'b1, addr: addr, write: (wr != 0), size: 3'd2,
                                  trans: NONSEQ, prio: PRIO_W'(prio)});
        end
        vecCount++;
      end else if (n > 0) begin
        stopOnError("Malformed line in the vector file");
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Master driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic runXfer(input int m, input int v);
    ahbRsp_t expRsp;
    ahbRsp_t errRsp;
    int      waits;
    string   name;
    name   = $sformatf("mstRsp[%0d]", m);
    expRsp = '{rdata: vRdata[v], ready: 1'b1, resp: vResp[v]};
    errRsp = '{rdata: vRdata[v], ready: 1'b0, resp: ERROR};
    waits  = 0;
    mstReq[m] = '{sel: 1'b1, addr: vAddr[v], write: vWrite[v], size: 3'd2,
                  trans: NONSEQ, prio: vPrio[v]};
    // Address phase ends on the first edge with ready high
    do begin
      @(negedge HCLK);
    end while (!mstRsp[m].ready);
    @(posedge HCLK);
    #2;
    mstReq[m].sel   = 1'b0;
    mstReq[m].trans = IDLE;
    mstHwdata[m]    = vWrite[v] ? vWdata[v] : '0;
    // Data phase stretched by a pending grant or slave wait states
    forever begin
      @(negedge HCLK);
      if (mstRsp[m].ready) begin
        break;
      end
      if (vResp[v] == ERROR && waits == 0) begin
        checkRsp(name, mstRsp[m], errRsp);
      end else if (mstRsp[m].resp != OKAY) begin
        stopOnError($sformatf("Master %0d saw ERROR while waiting on a good transfer", m));
      end
      waits++;
    end
    if (vResp[v] == ERROR && waits != 1) begin
      stopOnError($sformatf("Master %0d ERROR response did not take two cycles", m));
    end
    checkRsp(name, mstRsp[m], expRsp);
    @(posedge HCLK);
    #2;
  endtask

  // Slave-side order of accepted address phases
  always @(negedge HCLK) begin
    if (rstN) begin
      for (int s = 0; s < SLAVES; s++) begin
        // HREADY to a lone slave follows its own HREADYOUT
        checkReady($sformatf("slvHready[%0d]", s), slvHready[s], slvRsp[s].ready);
        if (slvReq[s].sel && slvHready[s]) begin
          if (expOrder[s].size() == 0) begin
            stopOnError($sformatf("Slave %0d saw an unexpected address phase", s));
          end else begin
            checkReq($sformatf("slvReq[%0d]", s), slvReq[s], expOrder[s].pop_front());
          end
        end
      end
      if (ahbMatrix_i.checker_i.assertFails != 0) begin
        stopOnError("A bound assertion failed");
      end
    end
  end

  // Watchdog allows ten cycles per vector
  initial begin
    wait (vecsLoaded);
    repeat (vecCount * 10 + 4) @(posedge HCLK);
    stopOnError("Timeout, the run hung with transfers outstanding");
  end

  initial begin
    int pick [MASTERS];
    int v;
    int step;
    int leftover;
    rstN      = 1'b0;
    mstReq    = '0;
    mstHwdata = '0;
    mstHready = '1;
    readVectors();
    vecsLoaded = 1'b1;
    repeat (4) @(posedge HCLK);
    #2;
    rstN = 1'b1;
    v    = 0;
    // All lines of one step start in the same cycle
    while (v < vecCount) begin
      step = vStep[v];
      for (int m = 0; m < MASTERS; m++) begin
        pick[m] = -1;
      end
      while (v < vecCount && vStep[v] == step) begin
        pick[vMst[v]] = v;
        v++;
      end
      for (int m = 0; m < MASTERS; m++) begin
        automatic int mm = m;
        if (pick[mm] >= 0) begin
          fork
            runXfer(mm, pick[mm]);
          join_none
        end
      end
      wait fork;
    end
    leftover = 0;
    for (int s = 0; s < SLAVES; s++) begin
      leftover += expOrder[s].size();
    end
    if (leftover != 0) begin
      stopOnError("A slave never saw an expected address phase");
    end else if (ahbMatrix_i.checker_i.assertFails != 0) begin
      stopOnError("A bound assertion failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- test/ahbMatrixVectors.txt
# step master write addr wdata rdata resp(0 OKAY 1 ERROR) prio, addr and data in hex
# Lines of one step start in the same cycle and are listed in expected grant order
0 0 1 00000010 a5a50001 00000000 0 1
1 0 0 00000010 00000000 a5a50001 0 1
2 0 1 10000020 5a5a0002 00000000 0 1
3 0 0 10000020 00000000 5a5a0002 0 1
4 1 0 20000000 00000000 00000000 1 1
5 1 1 00000030 11110003 00000000 0 5
5 0 1 00000034 22220004 00000000 0 1
6 1 0 00000034 00000000 22220004 0 5
6 0 0 00000030 00000000 11110003 0 1
7 1 1 10000040 33330005 00000000 0 2
7 0 1 10000044 44440006 00000000 0 2
8 1 0 10000044 00000000 44440006 0 2
8 0 0 10000040 00000000 33330005 0 2
9 0 1 00000050 55550007 00000000 0 0
9 1 1 10000050 66660008 00000000 0 0
10 0 0 00000050 00000000 55550007 0 0
10 1 0 10000050 00000000 66660008 0 0

//--- test/ahbMatrix_checker.sv
// Concurrent assertions on grants and master responses, bound into the matrix top

module ahbMatrix_checker import ahbMatrixPkg::*; #(
  parameter int MASTERS = 2,
  parameter int SLAVES  = 2
) (
  input logic                           HCLK,
  input logic                           rstN,
  input logic [SLAVES-1:0][MASTERS-1:0] grant,
  input ahbRsp_t [MASTERS-1:0]          mstRsp
);

  timeunit 1ns;
  timeprecision 1ps;

  // Longest wait a master may see, pending grant plus slave wait states
  localparam int MAX_WAIT = 16;

  int assertFails = 0;
  int waitCnt [MASTERS];

  // Consecutive not-ready cycles per master
  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      for (int m = 0; m < MASTERS; m++) begin
        waitCnt[m] <= 0;
      end
    end else begin
      for (int m = 0; m < MASTERS; m++) begin
        waitCnt[m] <= mstRsp[m].ready ? 0 : waitCnt[m] + 1;
      end
    end
  end

  for (genvar s = 0; s < SLAVES; s++) begin : genSlv
    // At most one master owns a slave
    assert property (@(posedge HCLK) disable iff (!rstN) $onehot0(grant[s]))
      else begin
        $error("grant of slave %0d is not one-hot", s);
        assertFails++;
      end
  end

  for (genvar m = 0; m < MASTERS; m++) begin : genMst
    // ERROR low-ready is always followed by ERROR high-ready
    assert property (@(posedge HCLK) disable iff (!rstN)
      (mstRsp[m].resp == ERROR && !mstRsp[m].ready) |=>
      (mstRsp[m].resp == ERROR && mstRsp[m].ready))
      else begin
        $error("master %0d ERROR response lost its second cycle", m);
        assertFails++;
      end

    // Pending master gets through eventually
    assert property (@(posedge HCLK) disable iff (!rstN) waitCnt[m] < MAX_WAIT)
      else begin
        $error("master %0d stuck not ready", m);
        assertFails++;
      end
  end

endmodule

bind ahbMatrix ahbMatrix_checker #(
  .MASTERS(MASTERS),
  .SLAVES (SLAVES)
) checker_i (
  .HCLK  (HCLK),
  .rstN  (rstN),
  .grant (grant),
  .mstRsp(mstRsp)
);

//--- test/ahbSlaveMem.sv
// Behavioural AHB-Lite slave memory for the testbench, one per slave port, with random wait states

module ahbSlaveMem import ahbMatrixPkg::*; (
  input  logic              HCLK,
  input  logic              rstN,
  input  ahbReq_t           req,
  input  logic [DATA_W-1:0] hwdata,
  input  logic              hready,
  output ahbRsp_t           rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0] mem [64];
  logic [31:0]       lfsrQ;
  logic [31:0]       lfsr1;
  logic [31:0]       lfsr2;
  logic              activeQ;
  logic              writeQ;
  logic              accept;
  logic [5:0]        idxQ;
  logic [1:0]        waitQ;
  logic [1:0]        waitNew;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per wait-state bit
  assign lfsr1   = lfsrNext(lfsrQ);
  assign lfsr2   = lfsrNext(lfsr1);
  assign waitNew = ({lfsr2[0], lfsr1[0]} == 2'd3) ? 2'd2 : {lfsr2[0], lfsr1[0]};

  assign accept = req.sel && (req.trans == NONSEQ || req.trans == SEQ) && hready;

  always_ff @(posedge HCLK) begin
    if (!rstN) begin
      activeQ <= 1'b0;
      writeQ  <= 1'b0;
      idxQ    <= '0;
      waitQ   <= '0;
      lfsrQ   <= 32'he1ca_152d;
    end else if (rsp.ready) begin
      // Write data lands on the edge that ends its data phase
      if (activeQ && writeQ) begin
        mem[idxQ] <= hwdata;
      end
      activeQ <= accept;
      writeQ  <= req.write;
      idxQ    <= req.addr[7:2];
      if (accept) begin
        waitQ <= waitNew;
        lfsrQ <= lfsr2;
      end
    end else begin
      waitQ <= waitQ - 2'd1;
    end
  end

  // HREADYOUT low while wait states remain
  assign rsp.ready = !(activeQ && waitQ != 2'd0);
  assign rsp.rdata = (activeQ && !writeQ) ? mem[idxQ] : '0;
  assign rsp.resp  = OKAY;

endmodule
